//--- pipe_trace_top.f
source/pipe_pkg.sv
source/credit_buffer.sv
source/instr_fetch.sv
source/decode_hazard.sv
source/exec_stage.sv
source/mem_wb_stage.sv
source/pipe_tracker.sv
source/pipe_trace_top.sv
testbench/pipe_trace_tb.sv

//--- source/credit_buffer.sv
`timescale 1ns/10ps

module credit_buffer #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t head,
    output logic     empty,
    output logic     full,
    output logic     credit
);
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    payload_t           store [depth];
    logic [ptr_w-1:0]   wr_ptr;
    logic [ptr_w-1:0]   rd_ptr;
    logic [ptr_w:0]     count;
    logic               do_push;
    logic               do_pop;

    function automatic logic [ptr_w-1:0] next_ptr(logic [ptr_w-1:0] ptr);
        return (ptr == ptr_w'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty   = (count == '0);
    assign full    = (count == (ptr_w + 1)'(depth));
    assign do_pop  = pop && !empty;
    // A full buffer still takes a push when the head leaves in the same cycle
    assign do_push = push && (!full || do_pop);
    assign head    = store[rd_ptr];
    // Each pop hands one credit back to the sender
    assign credit  = do_pop;

    always_ff @(posedge clk) begin
        if (do_push) begin
            store[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/decode_hazard.sv
`timescale 1ns/10ps

module decode_hazard (
    input  logic             clk,
    input  logic             rst,
    input  logic             fd_valid,
    input  pipe_pkg::instr_t fd_instr,
    input  pipe_pkg::ex_t    em_reg,
    input  pipe_pkg::wb_t    wb,
    input  logic             freeze,
    output logic             hazard_hold,
    output pipe_pkg::dec_t   de_reg
);
    import pipe_pkg::*;

    logic [data_w-1:0] regs [num_regs];
    logic [data_w-1:0] rs_val;
    logic [data_w-1:0] rt_val;
    logic              ld_in_ex;
    logic              rs_hit;
    logic              rt_hit;

    // Newest value first; an LD in memory has only its address in em_reg
    function automatic logic [data_w-1:0] read_bypass(
        logic [reg_idx_w-1:0] idx,
        logic [data_w-1:0]    file_val
    );
        if (em_reg.valid && writes_rd(em_reg.opcode) && em_reg.opcode != LD &&
            em_reg.rd == idx) begin
            return em_reg.result;
        end
        if (wb.valid && wb.we && wb.rd == idx) begin
            return wb.value;
        end
        return file_val;
    endfunction

    always_comb begin
        rs_val = read_bypass(fd_instr.rs, regs[fd_instr.rs]);
        rt_val = read_bypass(fd_instr.rt, regs[fd_instr.rt]);
    end

    // Load-use check against the instruction now in execute
    assign ld_in_ex    = de_reg.valid && de_reg.opcode == LD;
    assign rs_hit      = reads_rs(fd_instr.opcode) && fd_instr.rs == de_reg.rd;
    assign rt_hit      = reads_rt(fd_instr.opcode) && fd_instr.rt == de_reg.rd;
    assign hazard_hold = fd_valid && ld_in_ex && (rs_hit || rt_hit);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (!freeze && wb.valid && wb.we) begin
            regs[wb.rd] <= wb.value;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            de_reg <= '0;
        end else if (!freeze) begin
            if (fd_valid && !hazard_hold) begin
                de_reg <= '{valid:  1'b1,
                            opcode: fd_instr.opcode,
                            rd:     fd_instr.rd,
                            rs:     fd_instr.rs,
                            rt:     fd_instr.rt,
                            rs_val: rs_val,
                            rt_val: rt_val,
                            imm:    fd_instr.imm};
            end else begin
                // Bubble into execute
                de_reg <= '0;
            end
        end
    end

endmodule

//--- source/exec_stage.sv
`timescale 1ns/10ps

module exec_stage (
    input  logic           clk,
    input  logic           rst,
    input  pipe_pkg::dec_t de_reg,
    input  pipe_pkg::ex_t  em_reg,
    input  pipe_pkg::wb_t  wb,
    input  logic           freeze,
    output pipe_pkg::ex_t  em_next
);
    import pipe_pkg::*;

    logic [data_w-1:0] op_a;
    logic [data_w-1:0] op_b;
    logic [data_w-1:0] result;

    // LD in memory is excluded, decode already stalled for that case
    function automatic logic [data_w-1:0] forward(
        logic [reg_idx_w-1:0] idx,
        logic [data_w-1:0]    dec_val
    );
        if (em_reg.valid && writes_rd(em_reg.opcode) && em_reg.opcode != LD &&
            em_reg.rd == idx) begin
            return em_reg.result;
        end
        if (wb.valid && wb.we && wb.rd == idx) begin
            return wb.value;
        end
        return dec_val;
    endfunction

    always_comb begin
        op_a = forward(de_reg.rs, de_reg.rs_val);
        op_b = forward(de_reg.rt, de_reg.rt_val);
        case (de_reg.opcode)
            ADD:     result = op_a + op_b;
            SUB:     result = op_a - op_b;
            AND:     result = op_a & op_b;
            ADDI:    result = op_a + data_w'(de_reg.imm);
            // Address wraps within the data memory
            LD, ST:  result = data_w'(addr_w'(op_a[addr_w-1:0] + addr_w'(de_reg.imm)));
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            em_next <= '0;
        end else if (!freeze) begin
            em_next <= '{valid:      de_reg.valid,
                         opcode:     de_reg.opcode,
                         rd:         de_reg.rd,
                         result:     result,
                         store_data: op_b};
        end
    end

endmodule

//--- source/instr_fetch.sv
`timescale 1ns/10ps

module instr_fetch (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  pipe_pkg::instr_t in_instr,
    input  logic             freeze,
    input  logic             hazard_hold,
    output logic             in_credit,
    output logic             fd_valid,
    output pipe_pkg::instr_t fd_instr
);
    import pipe_pkg::*;

    instr_t buf_head;
    logic   buf_empty;
    logic   advance;

    // The fetch/decode register moves unless the pipe is frozen or decode stalls
    assign advance = !freeze && !hazard_hold;

    credit_buffer #(
        .payload_t (instr_t),
        .depth     (in_credits)
    ) u_in_buf (
        .clk       (clk),
        .rst       (rst),
        .push      (in_valid),
        .push_data (in_instr),
        .pop       (advance),
        .head      (buf_head),
        .empty     (buf_empty),
        .full      (),
        .credit    (in_credit)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fd_valid <= 1'b0;
            fd_instr <= '0;
        end else if (advance) begin
            // Bubble when nothing is waiting
            fd_valid <= !buf_empty;
            fd_instr <= buf_empty ? '0 : buf_head;
        end
    end

endmodule

//--- source/mem_wb_stage.sv
`timescale 1ns/10ps

module mem_wb_stage (
    input  logic          clk,
    input  logic          rst,
    input  pipe_pkg::ex_t em_reg,
    input  logic          freeze,
    output pipe_pkg::wb_t wb
);
    import pipe_pkg::*;

    logic [data_w-1:0] mem [mem_depth];
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] value;
    logic              store_en;

    assign addr     = em_reg.result[addr_w-1:0];
    assign store_en = em_reg.valid && em_reg.opcode == ST;

    // ST hands its stored byte down the writeback path for tracing
    always_comb begin
        case (em_reg.opcode)
            LD:      value = mem[addr];
            ST:      value = em_reg.store_data;
            default: value = em_reg.result;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < mem_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (!freeze && store_en) begin
            mem[addr] <= em_reg.store_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb <= '0;
        end else if (!freeze) begin
            wb <= '{valid: em_reg.valid,
                    we:    em_reg.valid && writes_rd(em_reg.opcode),
                    rd:    em_reg.rd,
                    value: value};
        end
    end

endmodule

//--- source/pipe_pkg.sv
package pipe_pkg;

    localparam int data_w      = 8;
    localparam int num_regs    = 8;
    localparam int mem_depth   = 16;
    localparam int in_credits  = 4;
    localparam int trace_depth = 4;

    // Derived field widths
    localparam int reg_idx_w = $clog2(num_regs);
    localparam int addr_w    = $clog2(mem_depth);
    localparam int imm_w     = 4;
    localparam int seq_w     = 8;
    localparam int hold_w    = 3;
    localparam int credit_w  = 8;

    typedef enum logic [2:0] {NOP, ADD, SUB, AND, ADDI, LD, ST} opcode_t;

    typedef struct packed {
        opcode_t              opcode;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs;
        logic [reg_idx_w-1:0] rt;
        logic [imm_w-1:0]     imm;
    } instr_t;

    // Decode/execute register
    typedef struct packed {
        logic                 valid;
        opcode_t              opcode;
        logic [reg_idx_w-1:0] rd;
        logic [reg_idx_w-1:0] rs;
        logic [reg_idx_w-1:0] rt;
        logic [data_w-1:0]    rs_val;
        logic [data_w-1:0]    rt_val;
        logic [imm_w-1:0]     imm;
    } dec_t;

    // Execute/memory register, result is the address for LD and ST
    typedef struct packed {
        logic                 valid;
        opcode_t              opcode;
        logic [reg_idx_w-1:0] rd;
        logic [data_w-1:0]    result;
        logic [data_w-1:0]    store_data;
    } ex_t;

    typedef struct packed {
        logic                 valid;
        logic                 we;
        logic [reg_idx_w-1:0] rd;
        logic [data_w-1:0]    value;
    } wb_t;

    typedef struct packed {
        logic [seq_w-1:0]     seq;
        opcode_t              opcode;
        logic [reg_idx_w-1:0] rd;
        logic [data_w-1:0]    value;
        logic [hold_w-1:0]    hold_cycles;
    } trace_rec_t;

    function automatic logic writes_rd(opcode_t op);
        return op inside {ADD, SUB, AND, ADDI, LD};
    endfunction

    function automatic logic reads_rs(opcode_t op);
        return op != NOP;
    endfunction

    // ST reads rt as its store data
    function automatic logic reads_rt(opcode_t op);
        return op inside {ADD, SUB, AND, ST};
    endfunction

endpackage

//--- source/pipe_trace_top.sv
`timescale 1ns/10ps

module pipe_trace_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 in_valid,
    input  pipe_pkg::instr_t     in_instr,
    output logic                 in_credit,
    input  logic                 trace_credit,
    output logic                 trace_valid,
    output pipe_pkg::trace_rec_t trace_rec
);
    import pipe_pkg::*;

    logic   fd_valid;
    instr_t fd_instr;
    dec_t   de_reg;
    ex_t    em_reg;
    wb_t    wb;
    logic   hazard_hold;
    logic   freeze;

    instr_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .freeze      (freeze),
        .hazard_hold (hazard_hold),
        .in_credit   (in_credit),
        .fd_valid    (fd_valid),
        .fd_instr    (fd_instr)
    );

    decode_hazard u_decode (
        .clk         (clk),
        .rst         (rst),
        .fd_valid    (fd_valid),
        .fd_instr    (fd_instr),
        .em_reg      (em_reg),
        .wb          (wb),
        .freeze      (freeze),
        .hazard_hold (hazard_hold),
        .de_reg      (de_reg)
    );

    exec_stage u_exec (
        .clk     (clk),
        .rst     (rst),
        .de_reg  (de_reg),
        .em_reg  (em_reg),
        .wb      (wb),
        .freeze  (freeze),
        .em_next (em_reg)
    );

    mem_wb_stage u_mem_wb (
        .clk    (clk),
        .rst    (rst),
        .em_reg (em_reg),
        .freeze (freeze),
        .wb     (wb)
    );

    // Follows each instruction from decode to retirement
    pipe_tracker u_tracker (
        .clk          (clk),
        .rst          (rst),
        .fd_valid     (fd_valid),
        .fd_instr     (fd_instr),
        .hazard_hold  (hazard_hold),
        .wb           (wb),
        .trace_credit (trace_credit),
        .freeze       (freeze),
        .trace_valid  (trace_valid),
        .trace_rec    (trace_rec)
    );

endmodule

//--- source/pipe_tracker.sv
`timescale 1ns/10ps

module pipe_tracker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fd_valid,
    input  pipe_pkg::instr_t     fd_instr,
    input  logic                 hazard_hold,
    input  pipe_pkg::wb_t        wb,
    input  logic                 trace_credit,
    output logic                 freeze,
    output logic                 trace_valid,
    output pipe_pkg::trace_rec_t trace_rec
);
    import pipe_pkg::*;

    // One shadow entry per stage, mirrors what the datapath holds
    typedef struct packed {
        logic                 valid;
        logic [seq_w-1:0]     seq;
        opcode_t              opcode;
        logic [reg_idx_w-1:0] rd;
        logic [hold_w-1:0]    hold;
    } shadow_t;

    shadow_t                          sh_dec;
    shadow_t                          sh_ex;
    shadow_t                          sh_mem;
    shadow_t                          sh_wb;
    logic [seq_w-1:0]                 seq_cnt;
    logic [hold_w-1:0]                dec_hold;
    logic [credit_w-1:0]              credit_cnt;
    logic [$clog2(trace_depth+1)-1:0] occ;
    logic [1:0]                       inflight;
    logic                             rec_push;
    logic                             rec_popped;
    logic                             buf_empty;
    trace_rec_t                       rec_in;

    // Decode entry is built live from the fetch/decode register
    assign sh_dec = '{valid:  fd_valid,
                      seq:    seq_cnt,
                      opcode: fd_instr.opcode,
                      rd:     fd_instr.rd,
                      hold:   dec_hold};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sh_ex    <= '0;
            sh_mem   <= '0;
            sh_wb    <= '0;
            seq_cnt  <= '0;
            dec_hold <= '0;
        end else if (!freeze) begin
            if (hazard_hold) begin
                sh_ex <= '0;
                if (dec_hold != '1) begin
                    dec_hold <= dec_hold + 1'b1;
                end
            end else begin
                sh_ex    <= sh_dec;
                dec_hold <= '0;
                if (fd_valid) begin
                    seq_cnt <= seq_cnt + 1'b1;
                end
            end
            sh_mem <= sh_ex;
            sh_wb  <= sh_mem;
        end
    end

    // Retire the writeback instruction, wb.value also holds the ST byte
    assign rec_push = wb.valid && !freeze;
    assign rec_in   = '{seq:         sh_wb.seq,
                        opcode:      sh_wb.opcode,
                        rd:          sh_wb.rd,
                        value:       wb.value,
                        hold_cycles: sh_wb.hold};

    assign inflight    = 2'(sh_ex.valid) + 2'(sh_mem.valid) + 2'(sh_wb.valid);
    // Stop the pipe unless every instruction past decode is sure of a slot
    assign freeze      = (int'(occ) + int'(inflight)) > trace_depth;
    assign trace_valid = !buf_empty && credit_cnt != '0;

    credit_buffer #(
        .payload_t (trace_rec_t),
        .depth     (trace_depth)
    ) u_trace_buf (
        .clk       (clk),
        .rst       (rst),
        .push      (rec_push),
        .push_data (rec_in),
        .pop       (trace_valid),
        .head      (trace_rec),
        .empty     (buf_empty),
        .full      (),
        .credit    (rec_popped)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credit_cnt <= '0;
            occ        <= '0;
        end else begin
            case ({trace_credit, rec_popped})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            case ({rec_push, rec_popped})
                2'b10:   occ <= occ + 1'b1;
                2'b01:   occ <= occ - 1'b1;
                default: occ <= occ;
            endcase
        end
    end

endmodule

//--- testbench/pipe_trace_tb.sv
`timescale 1ns/10ps

module pipe_trace_tb;
    import pipe_pkg::*;

    localparam int num_rows = 28;

    // One program row with its section and the record the model expects
    typedef struct packed {
        instr_t     instr;
        logic [1:0] sec;
        trace_rec_t exp;
    } row_t;

    logic       clk;
    logic       rst;
    logic       in_valid;
    instr_t     in_instr;
    logic       in_credit;
    logic       trace_credit;
    logic       trace_valid;
    trace_rec_t trace_rec;

    row_t rows [num_rows];
    int   send_cyc [num_rows];
    int   row_fill = 0;
    int   cyc = 0;
    int   tx = 0;
    int   rx_count = 0;
    int   feed_credits = in_credits;
    int   in_credit_total = 0;
    int   credits_returned = 0;
    int   rec_errors = 0;
    int   bit_errors = 0;
    int   count_errors = 0;
    int   seed = 21;

    pipe_trace_top UUT (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_credit    (in_credit),
        .trace_credit (trace_credit),
        .trace_valid  (trace_valid),
        .trace_rec    (trace_rec)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic string rec_str(trace_rec_t r);
        return $sformatf("{seq %0d %s r%0d value %0d hold %0d}",
                         r.seq, r.opcode.name(), r.rd, r.value, r.hold_cycles);
    endfunction

    task automatic check_rec(input string name, input trace_rec_t got, input trace_rec_t exp);
        if (got !== exp) begin
            rec_errors++;
            $display("Error at %0t ns: %s is %s, expected %s",
                     $time, name, rec_str(got), rec_str(exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            bit_errors++;
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            count_errors++;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic add_row(input opcode_t op, input int rd, input int rs, input int rt,
                           input int imm, input int sec);
        rows[row_fill].instr = '{opcode: op, rd: 3'(rd), rs: 3'(rs), rt: 3'(rt), imm: 4'(imm)};
        rows[row_fill].sec   = 2'(sec);
        rows[row_fill].exp   = '0;
        row_fill++;
    endtask

    // Registers an instruction reads as operands
    function automatic bit depends_on(instr_t ins, logic [2:0] r);
        case (ins.opcode)
            ADD, SUB, AND, ST: return ins.rs == r || ins.rt == r;
            ADDI, LD:          return ins.rs == r;
            default:           return 1'b0;
        endcase
    endfunction

    // Program order model of the register file and data memory
    task automatic run_model();
        logic [7:0] regs [8];
        logic [7:0] mem [16];
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] val;
        logic [3:0] addr;
        logic [2:0] hold;
        instr_t     ins;
        instr_t     prev;
        for (int r = 0; r < 8; r++) regs[r] = '0;
        for (int m = 0; m < 16; m++) mem[m] = '0;
        prev = '0;
        for (int i = 0; i < num_rows; i++) begin
            ins  = rows[i].instr;
            a    = regs[ins.rs];
            b    = regs[ins.rt];
            addr = 4'(a + 8'(ins.imm));
            case (ins.opcode)
                ADD:     val = a + b;
                SUB:     val = a - b;
                AND:     val = a & b;
                ADDI:    val = a + 8'(ins.imm);
                LD:      val = mem[addr];
                ST: begin
                    mem[addr] = b;
                    val = b;
                end
                default: val = '0;
            endcase
            if (ins.opcode inside {ADD, SUB, AND, ADDI, LD}) regs[ins.rd] = val;
            // Load-use costs one decode cycle
            hold = (prev.opcode == LD && depends_on(ins, prev.rd)) ? 3'd1 : 3'd0;
            rows[i].exp = '{seq: 8'(i), opcode: ins.opcode, rd: ins.rd, value: val,
                            hold_cycles: hold};
            prev = ins;
        end
    endtask

    task automatic build_table();
        // Section 0 has ALU chains with full credit and fixed latency
        add_row(ADDI, 1, 0, 0, 5, 0);
        add_row(ADDI, 2, 1, 0, 3, 0);
        add_row(ADD,  3, 1, 2, 0, 0);
        add_row(SUB,  4, 3, 1, 0, 0);
        add_row(AND,  5, 4, 3, 0, 0);
        add_row(ADD,  6, 5, 5, 0, 0);
        add_row(SUB,  7, 1, 6, 0, 0);
        add_row(ADDI, 7, 7, 0, 15, 0);
        add_row(NOP,  0, 0, 0, 0, 0);
        add_row(ADD,  0, 7, 6, 0, 0);
        // Section 1 has stores, loads and load-use stalls
        add_row(ST,   0, 1, 3, 2, 1);
        add_row(LD,   2, 1, 0, 2, 1);
        add_row(ADD,  4, 2, 1, 0, 1);
        add_row(ADDI, 5, 2, 0, 1, 1);
        add_row(LD,   6, 1, 0, 2, 1);
        add_row(ST,   0, 6, 5, 1, 1);
        add_row(LD,   7, 3, 0, 1, 1);
        add_row(LD,   1, 7, 0, 0, 1);
        // Section 2 runs with random output credits
        add_row(ADD,  2, 1, 7, 0, 2);
        add_row(SUB,  3, 2, 0, 0, 2);
        add_row(ST,   0, 0, 3, 5, 2);
        add_row(LD,   4, 3, 0, 1, 2);
        add_row(AND,  5, 4, 2, 0, 2);
        add_row(ADDI, 6, 5, 0, 7, 2);
        add_row(ADD,  7, 6, 6, 0, 2);
        add_row(NOP,  0, 0, 0, 0, 2);
        add_row(SUB,  0, 7, 4, 0, 2);
        add_row(ADDI, 1, 0, 0, 9, 2);
    endtask

    initial begin : watchdog
        repeat (4 + num_rows * 20 + 200) @(posedge clk);
        $display("Watchdog expired with %0d of %0d trace records received",
                 rx_count, num_rows);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        int         idle_left;
        int         sec;
        int         over;
        logic [31:0] rnd;
        logic       give;
        rst          = 1'b1;
        in_valid     = 1'b0;
        in_instr     = '0;
        trace_credit = 1'b0;
        idle_left    = 3;
        build_table();
        run_model();
        repeat (4) @(posedge clk);
        #2 rst = 1'b0;
        while (rx_count < num_rows) begin
            @(posedge clk);
            cyc++;
            #2;
            in_valid     = 1'b0;
            trace_credit = 1'b0;
            if (idle_left > 0) begin
                idle_left--;
            end else begin
                sec = (tx < num_rows) ? int'(rows[tx].sec) : 3;
                if (tx < num_rows && feed_credits > 0) begin
                    in_valid     = 1'b1;
                    in_instr     = rows[tx].instr;
                    send_cyc[tx] = cyc;
                    feed_credits--;
                    tx++;
                end
                rnd  = $random(seed);
                give = (sec == 2) ? rnd[0] : 1'b1;
                // Keep the outstanding credits bounded
                if (credits_returned - rx_count >= 8) give = 1'b0;
                trace_credit = give;
            end
            @(negedge clk);
            if (tx == 0) begin
                check_bit("in_credit", in_credit, 1'b0);
                check_bit("trace_valid", trace_valid, 1'b0);
            end
            if (in_credit) begin
                feed_credits++;
                in_credit_total++;
            end
            if (trace_valid) begin
                over = (rx_count + 1 > credits_returned) ? rx_count + 1 - credits_returned : 0;
                check_count("records beyond returned credits", over, 0);
                check_rec("trace_rec", trace_rec, rows[rx_count].exp);
                if (rows[rx_count].sec == 2'd0) begin
                    check_count("trace latency in cycles", cyc - send_cyc[rx_count], 6);
                end
                rx_count++;
            end
            if (trace_credit) credits_returned++;
        end
        // Nothing may follow the last record
        repeat (10) begin
            @(negedge clk);
            check_bit("trace_valid", trace_valid, 1'b0);
        end
        check_count("in_credit pulses", in_credit_total, num_rows);
        $display("Errors: record %0d, bit %0d, count %0d", rec_errors, bit_errors, count_errors);
        if (rec_errors + bit_errors + count_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule
